// ==== hw/tmu_wb_alloc.sv ====
// entry allocator: merges pixels into the open block, opens new entries, tracks the level
`timescale 1ns/1ps

module tmu_wb_alloc import tmu_wb_pkg::*; (
	input  logic                  sys_clk,
	input  logic                  sys_rst,
	input  logic                  pipe_stb,
	input  logic                  flush,
	input  logic [pix_w-1:0]      color,
	input  logic [fml_depth-2:0]  dadr,        // halfword address
	output logic                  pipe_ack,
	output logic                  busy,
	tmu_wb_tag_if.ctrl            fill_tag,
	output logic [slot_w-1:0]     wr_slot,
	output logic [1:0]            wr_word,
	output logic [1:0]            wr_lane,
	output logic                  wr_en,
	output logic [pix_w-1:0]      wr_color,
	output logic                  pending,
	input  logic                  done,
	input  logic [slot_w-1:0]     head_slot
);

	logic [fml_depth-1:0] dadr8;
	logic [blk_adr_w-1:0] blk_start;
	logic [1:0]           word_idx;
	logic [1:0]           lane_idx;
	logic [lane_cnt-1:0]  lane_bit;
	logic [slot_w-1:0]    cur_slot;
	logic [blk_adr_w-1:0] cur_start;
	logic                 cur_has_en;
	logic [level_w-1:0]   level;
	logic                 accept;
	logic                 hit;
	logic                 new_entry;

	// ------------------------------------------------------------------------
	// address decode
	// ------------------------------------------------------------------------
	assign dadr8     = {dadr, 1'b0};                // byte address
	assign blk_start = dadr8[fml_depth-1:5];        // burst start
	assign word_idx  = dadr8[4:3];                  // 64-bit beat within burst
	assign lane_idx  = dadr8[2:1];                  // halfword within beat
	assign lane_bit  = {1'b1, {(lane_cnt-1){1'b0}}} >> {word_idx, lane_idx};

	// ------------------------------------------------------------------------
	// hit / new entry
	// ------------------------------------------------------------------------
	// the open entry is safe to extend only while it is not the head
	// being drained, which holds exactly when two or more are pending
	assign hit = (cur_start == blk_start) & cur_has_en
		& (level >= level_w'(2)) & (cur_slot != head_slot);

	assign accept    = pipe_stb & pipe_ack;
	assign new_entry = accept & (flush | ~hit);

	assign fill_tag.slot        = (flush | ~hit) ? cur_slot + slot_w'(1) : cur_slot;
	assign fill_tag.we          = accept;
	assign fill_tag.wdata.start = blk_start;
	assign fill_tag.wdata.en    = flush ? '0
		: (hit ? (fill_tag.rdata.en | lane_bit) : lane_bit);   // merge or fresh

	assign wr_slot  = fill_tag.slot;   // data follows the tag slot
	assign wr_word  = word_idx;
	assign wr_lane  = lane_idx;
	assign wr_en    = accept & ~flush; // flush beats carry no color
	assign wr_color = color;

	// cur_* mirror the tag of cur_slot so the hit test never reads the port
	// whose slot it selects
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			cur_slot   <= '1;          // first entry lands in slot 0
			cur_start  <= '0;
			cur_has_en <= 1'b0;
			level      <= '0;
		end else begin
			if (accept) begin
				cur_slot   <= fill_tag.slot;
				cur_start  <= blk_start;
				cur_has_en <= ~flush;
			end
			level <= level + level_w'(new_entry) - level_w'(done);
		end
	end

	assign pipe_ack = ~level[level_w-1];  // level below four
	assign busy     = |level;
	assign pending  = |level;

	// never more than four entries in flight
	assert property (@(posedge sys_clk) disable iff (sys_rst) level <= level_w'(4));
	// drain only retires entries that were counted
	assert property (@(posedge sys_clk) disable iff (sys_rst) done |-> level != '0);

endmodule

// ==== hw/tmu_wb_burst.sv ====
// drain engine: turns the head entry into one four-beat FML write burst
`timescale 1ns/1ps

module tmu_wb_burst import tmu_wb_pkg::*; (
	input  logic                  sys_clk,
	input  logic                  sys_rst,
	input  logic                  pending,     // entries waiting
	output logic                  done,        // head entry retired
	output logic [slot_w-1:0]     head_slot,
	tmu_wb_tag_if.ctrl            drain_tag,
	output logic [slot_w+1:0]     rd_addr,
	input  logic [4*pix_w-1:0]    rd_data,
	output logic [fml_depth-1:0]  fml_adr,
	output logic                  fml_stb,
	output logic [7:0]            fml_sel,
	output logic [4*pix_w-1:0]    fml_do,
	input  logic                  fml_ack
);

	drain_state_t state;
	drain_state_t state_nxt;
	logic [1:0]   beat;
	logic [1:0]   beat_nxt;
	logic         beat_adv;
	logic [3:0]   grp;
	logic         empty;
	tag_entry_t   tag;

	// ------------------------------------------------------------------------
	// head tag, read only
	// ------------------------------------------------------------------------
	assign drain_tag.slot  = head_slot;
	assign drain_tag.we    = 1'b0;
	assign drain_tag.wdata = '0;
	assign tag             = drain_tag.rdata;
	assign empty           = (tag.en == '0);   // flush entry, no memory traffic

	// ------------------------------------------------------------------------
	// FSM
	// ------------------------------------------------------------------------
	always_comb begin
		state_nxt = state;
		fml_stb   = 1'b0;
		done      = 1'b0;
		case (state)
			idle: begin
				if (pending) begin
					state_nxt = empty ? word4 : word1;
				end
			end
			word1: begin
				fml_stb = 1'b1;              // held until the controller takes it
				if (fml_ack) begin
					state_nxt = word2;   // beat 0 goes out now
				end
			end
			word2: state_nxt = word3;
			word3: state_nxt = word4;
			word4: begin
				done      = 1'b1;
				state_nxt = idle;
			end
			default: state_nxt = idle;
		endcase
	end

	// beat counter runs from the ack cycle through word3
	assign beat_adv = ((state == word1) & fml_ack) | (state == word2) | (state == word3);
	assign beat_nxt = beat_adv ? beat + 2'd1 : 2'd0;
	assign rd_addr  = {head_slot, beat_nxt};    // registered read, one ahead

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state     <= idle;
			beat      <= 2'd0;
			head_slot <= '0;
		end else begin
			state <= state_nxt;
			beat  <= beat_nxt;
			if (done) begin
				head_slot <= head_slot + slot_w'(1);   // next entry in order
			end
		end
	end

	// ------------------------------------------------------------------------
	// memory side outputs
	// ------------------------------------------------------------------------
	assign grp     = tag.en[(lane_cnt-1) - {beat, 2'b00} -: 4];   // enables for this beat
	assign fml_sel = (state == idle) ? 8'h00
		: {{2{grp[3]}}, {2{grp[2]}}, {2{grp[1]}}, {2{grp[0]}}};
	assign fml_adr = {tag.start, 5'b00000};
	assign fml_do  = rd_data;

	// the strobe may only drop once the controller has accepted
	assert property (@(posedge sys_clk) disable iff (sys_rst)
		fml_stb && !fml_ack |=> fml_stb);

endmodule

// ==== hw/tmu_wb_datamem.sv ====
// block data store, 16 x 64 bits, halfword lane writes and one registered read port
`timescale 1ns/1ps

module tmu_wb_datamem import tmu_wb_pkg::*; (
	input  logic                  sys_clk,
	input  logic [slot_w-1:0]     wr_slot,    // entry
	input  logic [1:0]            wr_word,    // beat in entry
	input  logic [1:0]            wr_lane,    // halfword in beat, 0 is msb
	input  logic                  wr_en,
	input  logic [pix_w-1:0]      wr_color,
	input  logic [slot_w+1:0]     rd_addr,    // {slot, beat}, one cycle ahead
	output logic [4*pix_w-1:0]    rd_data
);

	logic [4*pix_w-1:0] mem [0:(1<<(slot_w+2))-1];
	logic [slot_w+1:0]  wr_addr;
	logic [5:0]         lane_lsb;

	// ------------------------------------------------------------------------
	// write side
	// ------------------------------------------------------------------------
	assign wr_addr  = {wr_slot, wr_word};
	assign lane_lsb = 6'd48 - {wr_lane, 4'b0000};   // lane 0 sits at 63:48

	always_ff @(posedge sys_clk) begin
		if (wr_en) begin
			mem[wr_addr][lane_lsb +: pix_w] <= wr_color;  // only this lane changes
		end
	end

	// ------------------------------------------------------------------------
	// read side
	// ------------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		rd_data <= mem[rd_addr];   // data valid the cycle after the address
	end

endmodule

// ==== hw/tmu_wb_pkg.sv ====
// shared geometry, tag layout and drain FSM encoding; imported by every write-back module

package tmu_wb_pkg;

	// ------------------------------------------------------------------------
	// frame memory geometry
	// ------------------------------------------------------------------------
	localparam int fml_depth = 26;              // byte address width of frame memory
	localparam int pix_w     = 16;              // one rgb565 color
	localparam int blk_adr_w = fml_depth - 5;   // 32-byte block start
	localparam int lane_cnt  = 16;              // halfwords per block

	// ------------------------------------------------------------------------
	// buffer geometry
	// ------------------------------------------------------------------------
	localparam int slot_w  = 2;                 // four block entries
	localparam int level_w = 3;                 // pending count, 0 to 4

	// one tag entry, enable bit 15 is halfword 0 of the block
	typedef struct packed {
		logic [blk_adr_w-1:0] start;            // block start address
		logic [lane_cnt-1:0]  en;               // halfword enables, zero for a flush
	} tag_entry_t;

	// drain engine states
	typedef enum logic [2:0] {
		idle,                                   // nothing to drain
		word1,                                  // strobe held until fml_ack
		word2,                                  // beat 1
		word3,                                  // beat 2
		word4                                   // beat 3, entry retires
	} drain_state_t;

endpackage

// ==== hw/tmu_wb_tag_if.sv ====
// one port of the tag store; the allocator and drain engine each hold one as ctrl
`timescale 1ns/1ps

interface tmu_wb_tag_if import tmu_wb_pkg::*; ();

	logic [slot_w-1:0] slot;   // entry index, read and write share it
	logic              we;     // write strobe
	tag_entry_t        wdata;  // entry to store
	tag_entry_t        rdata;  // entry at slot, combinational

	modport ctrl (
		output slot,
		output we,
		output wdata,
		input  rdata
	);

	modport mem (
		input  slot,
		input  we,
		input  wdata,
		output rdata
	);

endinterface

// ==== hw/tmu_wb_tagmem.sv ====
// four-entry tag store that the allocator writes and reads and the drain engine only reads
`timescale 1ns/1ps

module tmu_wb_tagmem import tmu_wb_pkg::*; (
	input  logic      sys_clk,
	tmu_wb_tag_if.mem fill,    // allocator side
	tmu_wb_tag_if.mem drain    // drain engine side
);

	tag_entry_t tags [0:(1<<slot_w)-1];

	// ------------------------------------------------------------------------
	// writes from the fill port only
	// ------------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (fill.we) begin
			tags[fill.slot] <= fill.wdata;
		end
	end

	// ------------------------------------------------------------------------
	// combinational reads on both ports
	// ------------------------------------------------------------------------
	assign fill.rdata  = tags[fill.slot];   // open entry for merging
	assign drain.rdata = tags[drain.slot];  // head entry for the burst

	// the drain engine never modifies tags
	assert property (@(posedge sys_clk) !drain.we);

endmodule

// ==== hw/tmu_wb_top.sv ====
// write-combining pixel write-back path, pixel stream in and FML write bursts out
`timescale 1ns/1ps

module tmu_wb_top import tmu_wb_pkg::*; (
	input  logic                  sys_clk,
	input  logic                  sys_rst,
	// pixel stream
	input  logic                  pipe_stb,
	output logic                  pipe_ack,
	input  logic [pix_w-1:0]      color,
	input  logic [fml_depth-2:0]  dadr,       // halfword address
	input  logic                  flush,      // beat opens an empty entry
	output logic                  busy,
	// frame memory
	output logic [fml_depth-1:0]  fml_adr,
	output logic                  fml_stb,
	input  logic                  fml_ack,
	output logic [7:0]            fml_sel,
	output logic [4*pix_w-1:0]    fml_do
);

	logic [slot_w-1:0]  wr_slot;
	logic [1:0]         wr_word;
	logic [1:0]         wr_lane;
	logic               wr_en;
	logic [pix_w-1:0]   wr_color;
	logic [slot_w+1:0]  rd_addr;
	logic [4*pix_w-1:0] rd_data;
	logic               pending;
	logic               done;
	logic [slot_w-1:0]  head_slot;

	tmu_wb_tag_if fill_tag ();    // allocator port
	tmu_wb_tag_if drain_tag ();   // drain engine port

	// ------------------------------------------------------------------------
	// allocation and storage
	// ------------------------------------------------------------------------
	tmu_wb_alloc alloc_i (
		.sys_clk   (sys_clk),
		.sys_rst   (sys_rst),
		.pipe_stb  (pipe_stb),
		.flush     (flush),
		.color     (color),
		.dadr      (dadr),
		.pipe_ack  (pipe_ack),
		.busy      (busy),
		.fill_tag  (fill_tag.ctrl),
		.wr_slot   (wr_slot),
		.wr_word   (wr_word),
		.wr_lane   (wr_lane),
		.wr_en     (wr_en),
		.wr_color  (wr_color),
		.pending   (pending),
		.done      (done),
		.head_slot (head_slot)
	);

	tmu_wb_tagmem tagmem_i (
		.sys_clk (sys_clk),
		.fill    (fill_tag.mem),
		.drain   (drain_tag.mem)
	);

	tmu_wb_datamem datamem_i (
		.sys_clk  (sys_clk),
		.wr_slot  (wr_slot),
		.wr_word  (wr_word),
		.wr_lane  (wr_lane),
		.wr_en    (wr_en),
		.wr_color (wr_color),
		.rd_addr  (rd_addr),
		.rd_data  (rd_data)
	);

	// ------------------------------------------------------------------------
	// drain to frame memory
	// ------------------------------------------------------------------------
	tmu_wb_burst burst_i (
		.sys_clk   (sys_clk),
		.sys_rst   (sys_rst),
		.pending   (pending),
		.done      (done),
		.head_slot (head_slot),
		.drain_tag (drain_tag.ctrl),
		.rd_addr   (rd_addr),
		.rd_data   (rd_data),
		.fml_adr   (fml_adr),
		.fml_stb   (fml_stb),
		.fml_sel   (fml_sel),
		.fml_do    (fml_do),
		.fml_ack   (fml_ack)
	);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the write-back testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert \
	-f tmu_wb_top.f \
	--top-module tmu_wb_tb \
	-o tmu_wb_sim

out=$(./obj_dir/tmu_wb_sim)
echo "$out"

if echo "$out" | grep -qxF '** PASS **'; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi

// ==== test/tmu_wb_check.sv ====
// testbench checker: rebuilds frame memory from FML bursts and compares it with the reference
`timescale 1ns/1ps

module tmu_wb_check import tmu_wb_pkg::*; (
	input logic                 sys_clk,
	input logic                 sys_rst,
	input logic [fml_depth-1:0] fml_adr,
	input logic                 fml_stb,
	input logic                 fml_ack,
	input logic [7:0]           fml_sel,
	input logic [63:0]          fml_do
);

	logic [7:0]           obs_mem [int];   // byte address -> observed byte
	bit                   checked [int];   // bytes covered by the reference
	logic [fml_depth-1:0] burst_adr;
	int                   beat;
	bit                   in_burst;
	int                   errors = 0;
	int                   burst_cnt = 0;
	int                   sel_bytes = 0;
	int                   stb_cycles = 0;

	// ------------------------------------------------------------------------
	// burst monitor, sampled mid-cycle
	// ------------------------------------------------------------------------
	task automatic apply_beat(input int b);
		for (int i = 0; i < 8; i++) begin
			if (fml_sel[7-i]) begin                  // sel bit 7 is the lowest byte
				obs_mem[int'(burst_adr) + b*8 + i] = fml_do[63-8*i -: 8];
				sel_bytes++;
			end
		end
	endtask

	always @(negedge sys_clk) begin
		if (!sys_rst) begin
			if (fml_stb) stb_cycles++;
			if (in_burst) begin
				apply_beat(beat);                    // beats 1 to 3 follow the ack
				if (beat == 3) in_burst = 0;
				else beat = beat + 1;
			end else if (fml_stb && fml_ack) begin
				burst_cnt++;
				burst_adr = fml_adr;
				apply_beat(0);                       // ack cycle carries beat 0
				beat = 1;
				in_burst = 1;
			end
		end
	end

	// ------------------------------------------------------------------------
	// comparison helpers called by the testbench
	// ------------------------------------------------------------------------
	task automatic clear_all();
		obs_mem.delete();
		checked.delete();
		burst_cnt = 0;
		sel_bytes = 0;
		stb_cycles = 0;
	endtask

	task automatic check_value(input string name, input string what, input int exp, input int act);
		if (exp != act) begin
			$display("CHECK FAILED %s %s expected %0h actual %0h", name, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_half(input string name, input int h, input logic [15:0] exp);
		logic [15:0] act;
		act = 16'hxxxx;                              // unwritten reads as x
		if (obs_mem.exists(2*h) && obs_mem.exists(2*h+1)) act = {obs_mem[2*h], obs_mem[2*h+1]};
		checked[2*h] = 1;
		checked[2*h+1] = 1;
		if (act !== exp) begin
			$display("CHECK FAILED %s halfword %0h expected %h actual %h", name, h, exp, act);
			errors++;
		end
	endtask

	task automatic check_unexpected(input string name);
		foreach (obs_mem[b]) begin
			if (!checked.exists(b)) begin
				$display("test %s wrote byte address %0h that no pixel targeted", name, b);
				errors++;
			end
		end
	endtask

endmodule

// ==== test/tmu_wb_tb.sv ====
// testbench top with clock, reset, pixel stimulus, FML responder and reference image for tmu_wb_top
`timescale 1ns/1ps

module tmu_wb_tb import tmu_wb_pkg::*;;

	logic                 sys_clk;
	logic                 sys_rst;
	logic                 pipe_stb, pipe_ack, flush, busy;
	logic [pix_w-1:0]     color;
	logic [fml_depth-2:0] dadr;
	logic [fml_depth-1:0] fml_adr;
	logic                 fml_stb, fml_ack;
	logic [7:0]           fml_sel;
	logic [63:0]          fml_do;
	logic [15:0]          exp_mem [int];   // halfword address -> last color
	bit                   hold_ack;
	int                   errors = 0;
	string                test;

	tmu_wb_top dut_i (.*);

	tmu_wb_check check_i (.sys_clk(sys_clk), .sys_rst(sys_rst), .fml_adr(fml_adr),
		.fml_stb(fml_stb), .fml_ack(fml_ack), .fml_sel(fml_sel), .fml_do(fml_do));

	initial begin
		sys_clk = 1'b0;
		forever #50 sys_clk = ~sys_clk;    // 100 ns period
	end

	// ------------------------------------------------------------------------
	// reference model and stimulus tasks
	// ------------------------------------------------------------------------
	function automatic void ref_write(input int h, input logic [15:0] c);
		exp_mem[h] = c;                           // last write wins
	endfunction

	task automatic drive_beat(input int h, input logic [15:0] c, input logic fl);
		@(posedge sys_clk);
		pipe_stb <= 1'b1;
		dadr     <= (fml_depth-1)'(h);
		color    <= c;
		flush    <= fl;
	endtask

	task automatic wait_accept(input int h, input logic [15:0] c, input logic fl);
		int t;
		t = 0;
		@(negedge sys_clk);
		while (!pipe_ack && t < 500) begin
			@(negedge sys_clk);
			t++;
		end
		if (!pipe_ack) begin
			$display("timeout in %s: pipe_ack never rose for a beat", test);
			errors++;
		end else if (!fl) begin
			ref_write(h, c);                  // transfer at the coming edge
		end
	endtask

	task automatic send_beat(input int h, input logic [15:0] c, input logic fl);
		drive_beat(h, c, fl);
		wait_accept(h, c, fl);
	endtask

	task automatic go_idle();
		@(posedge sys_clk);
		pipe_stb <= 1'b0;
		flush    <= 1'b0;
	endtask

	task automatic wait_busy_low();
		int t;
		t = 0;
		@(negedge sys_clk);
		while (busy && t < 2000) begin
			@(negedge sys_clk);
			t++;
		end
		if (busy) begin
			$display("timeout in %s: busy did not fall", test);
			errors++;
		end
		repeat (2) @(negedge sys_clk);
	endtask

	task automatic compare_image();
		foreach (exp_mem[h]) check_i.check_half(test, h, exp_mem[h]);
		check_i.check_unexpected(test);
	endtask

	task automatic start_test(input string name);
		test = name;
		exp_mem.delete();
		check_i.clear_all();
	endtask

	// ------------------------------------------------------------------------
	// FML responder with a random ack delay of 0 to 5 cycles
	// ------------------------------------------------------------------------
	initial begin
		int n;
		fml_ack = 1'b0;
		forever begin
			@(negedge sys_clk);
			if (fml_stb && !hold_ack) begin
				n = $urandom % 6;
				repeat (n) @(negedge sys_clk);
				@(posedge sys_clk);
				fml_ack <= 1'b1;
				@(posedge sys_clk);
				fml_ack <= 1'b0;
			end
		end
	end

	// ------------------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------------------
	initial begin
		int h;
		int total;
		void'($urandom(40905));
		sys_rst = 1'b1;
		pipe_stb = 1'b0;
		flush = 1'b0;
		color = '0;
		dadr = '0;
		hold_ack = 1'b0;

		test = "reset";
		repeat (3) begin
			@(negedge sys_clk);
			check_i.check_value(test, "pipe_ack in reset", 1, int'(pipe_ack));
			check_i.check_value(test, "busy in reset", 0, int'(busy));
			check_i.check_value(test, "fml_stb in reset", 0, int'(fml_stb));
		end
		@(posedge sys_clk);
		sys_rst <= 1'b0;                          // fourth rising edge still in reset
		@(negedge sys_clk);
		check_i.check_value(test, "pipe_ack after reset", 1, int'(pipe_ack));
		check_i.check_value(test, "busy after reset", 0, int'(busy));
		check_i.check_value(test, "fml_stb after reset", 0, int'(fml_stb));

		start_test("single");
		h = $urandom % (1 << 20);
		send_beat(h, 16'(($urandom)), 1'b0);
		send_beat(h, 16'h0, 1'b1);
		go_idle();
		wait_busy_low();
		check_i.check_value(test, "burst count", 1, check_i.burst_cnt);
		check_i.check_value(test, "selected bytes", 2, check_i.sel_bytes);
		check_i.check_value(test, "burst address", (2*h) & ~31, int'(check_i.burst_adr));
		compare_image();

		start_test("combine");
		for (int i = 0; i < 16; i++) begin
			send_beat(16'h200 + (i*7) % 16, 16'(($urandom)), 1'b0);   // stride 7 hits every lane
		end
		send_beat(16'h200, 16'h0, 1'b1);
		go_idle();
		wait_busy_low();
		compare_image();

		start_test("backpressure");
		hold_ack = 1'b1;                        // responder holds fml_ack low
		for (int k = 0; k < 4; k++) send_beat(16'h8000 + k*16, 16'(($urandom)), 1'b0);
		drive_beat(16'h8000 + 4*16, 16'hbeef, 1'b0);
		repeat (8) @(negedge sys_clk);
		check_i.check_value(test, "pipe_ack with four pending", 0, int'(pipe_ack));
		hold_ack = 1'b0;
		wait_accept(16'h8000 + 4*16, 16'hbeef, 1'b0);
		go_idle();
		wait_busy_low();
		compare_image();

		start_test("flush_only");
		send_beat(0, 16'h0, 1'b1);
		send_beat(0, 16'h0, 1'b1);
		go_idle();
		@(negedge sys_clk);
		check_i.check_value(test, "busy after flush", 1, int'(busy));
		wait_busy_low();
		check_i.check_value(test, "strobe cycles", 0, check_i.stb_cycles);
		compare_image();

		start_test("random");
		for (int i = 0; i < 300; i++) begin
			if ($urandom % 16 == 0) send_beat(0, 16'h0, 1'b1);   // stray flush
			send_beat(16'h4000 + $urandom % 128, 16'(($urandom)), 1'b0);
			if ($urandom % 4 == 0) go_idle();                     // gap in the stream
		end
		send_beat(0, 16'h0, 1'b1);
		go_idle();
		wait_busy_low();
		compare_image();

		total = errors + check_i.errors;
		$display("errors: %0d (stimulus %0d, checker %0d)", total, errors, check_i.errors);
		if (total == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// ==== tmu_wb_top.f ====
hw/tmu_wb_pkg.sv
hw/tmu_wb_tag_if.sv
hw/tmu_wb_alloc.sv
hw/tmu_wb_tagmem.sv
hw/tmu_wb_datamem.sv
hw/tmu_wb_burst.sv
hw/tmu_wb_top.sv
test/tmu_wb_check.sv
test/tmu_wb_tb.sv
